// File: common/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // Datapath and register index widths
    localparam int xlen     = 32;
    localparam int regAddrW = 5;

    // Instruction store, word addressed
    localparam int imemDepth = 256;
    localparam int imemAddrW = 8;

    // Data store wraps within this many words
    localparam int dmemDepth = 64;
    localparam int dmemAddrW = 6;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,  // add, sub, and, or, slt
        opImm    = 7'b0010011,  // addi
        opLoad   = 7'b0000011,  // lw
        opStore  = 7'b0100011,  // sw
        opBranch = 7'b1100011   // beq
    } opcodeT;

    // Operations the ALU understands
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4   // Signed compare
    } aluOpT;

endpackage

`default_nettype wire

// File: sources.f
common/cpuPkg.sv
verilog/fetchUnit.sv
verilog/instMem.sv
verilog/decodeControl.sv
verilog/regFile.sv
verilog/alu.sv
verilog/dataMem.sv
verilog/singleCpu.sv
test/tbSingleCpu.sv

// File: test/tbSingleCpu.sv
`timescale 1ns/100ps
`default_nettype none

module tbSingleCpu
    import cpuPkg::*;
();

    typedef enum int {
        insAdd, insSub, insAnd, insOr, insSlt, insAddi, insLw, insSw, insBeq, insBad
    } insKindT;

    logic                 CLK = 1'b0;
    logic                 arstN;
    logic                 runEn;
    logic                 imemWrEn;
    logic [imemAddrW-1:0] imemWrAddr;
    logic [xlen-1:0]      imemWrData;
    logic                 traceValid;
    logic                 wbEn;
    logic                 memWrEn;
    logic [xlen-1:0]      tracePc;
    logic [xlen-1:0]      traceInst;
    logic [xlen-1:0]      wbData;
    logic [xlen-1:0]      memAddr;
    logic [xlen-1:0]      memWrData;
    logic [regAddrW-1:0]  wbAddr;

    // Program kept as fields so the model never decodes words
    int                  progLen;
    insKindT             progKind [imemDepth];
    logic [regAddrW-1:0] progRd [imemDepth];
    logic [regAddrW-1:0] progRs1 [imemDepth];
    logic [regAddrW-1:0] progRs2 [imemDepth];
    logic [xlen-1:0]     progImm [imemDepth];
    logic [xlen-1:0]     progWord [imemDepth];
    logic [6:0]          badOps [4] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b0000000};

    // ISA model state
    logic [xlen-1:0]     modelRegs [32];
    logic [xlen-1:0]     modelMem [dmemDepth];
    logic [xlen-1:0]     modelPc;
    logic [xlen-1:0]     finalPc;    // Self-loop at the end of the program

    // Predicted trace of the retiring instruction
    logic [xlen-1:0]     expPc;
    logic [xlen-1:0]     expInst;
    logic                expWbEn;
    logic [regAddrW-1:0] expWbAddr;
    logic [xlen-1:0]     expWbData;
    logic                expStEn;
    logic [xlen-1:0]     expStAddr;
    logic [xlen-1:0]     expStData;

    always #50 CLK = ~CLK;

    singleCpu i_singleCpu (.*);

    function automatic int randRange(input int lo, input int hi);
        return lo + int'($urandom % (hi - lo + 1));
    endfunction

    // RV32I encodings of the supported subset
    function automatic logic [xlen-1:0] encodeInst(input insKindT kind,
            input logic [regAddrW-1:0] rd, input logic [regAddrW-1:0] rs1,
            input logic [regAddrW-1:0] rs2, input logic [xlen-1:0] imm);
        case (kind)
            insAdd:  return {7'b0000000, rs2, rs1, 3'b000, rd, opR};
            insSub:  return {7'b0100000, rs2, rs1, 3'b000, rd, opR};
            insAnd:  return {7'b0000000, rs2, rs1, 3'b111, rd, opR};
            insOr:   return {7'b0000000, rs2, rs1, 3'b110, rd, opR};
            insSlt:  return {7'b0000000, rs2, rs1, 3'b010, rd, opR};
            insAddi: return {imm[11:0], rs1, 3'b000, rd, opImm};
            insLw:   return {imm[11:0], rs1, 3'b010, rd, opLoad};
            insSw:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
            insBeq:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], opBranch};
            default: return '0;
        endcase
    endfunction

    task automatic stopRun();
        $display("test failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic checkValid(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAIL %s traceValid: expected %b, actual %b", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkPc(input string name, input logic [xlen-1:0] expected,
            input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s tracePc: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkInst(input string name, input logic [xlen-1:0] expected,
            input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s traceInst: expected %h, actual %h", name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkWb(input string name, input logic expEn,
            input logic [regAddrW-1:0] expAddr, input logic [xlen-1:0] expData,
            input logic actEn, input logic [regAddrW-1:0] actAddr,
            input logic [xlen-1:0] actData);
        if (actEn !== expEn) begin
            $display("FAIL %s wbEn: expected %b, actual %b", name, expEn, actEn);
            stopRun();
        end else if (expEn && (actAddr !== expAddr || actData !== expData)) begin
            $display("FAIL %s write-back: expected x%0d=%h, actual x%0d=%h",
                name, expAddr, expData, actAddr, actData);
            stopRun();
        end
    endtask

    task automatic checkStore(input string name, input logic expEn,
            input logic [xlen-1:0] expAddr, input logic [xlen-1:0] expData,
            input logic actEn, input logic [xlen-1:0] actAddr,
            input logic [xlen-1:0] actData);
        if (actEn !== expEn) begin
            $display("FAIL %s memWrEn: expected %b, actual %b", name, expEn, actEn);
            stopRun();
        end else if (expEn && (actAddr !== expAddr || actData !== expData)) begin
            $display("FAIL %s store: expected [%h]=%h, actual [%h]=%h",
                name, expAddr, expData, actAddr, actData);
            stopRun();
        end
    endtask

    // Nothing may retire while runEn is low
    task automatic checkIdle(input string name);
        checkValid(name, 1'b0, traceValid);
        checkWb(name, 1'b0, '0, '0, wbEn, wbAddr, wbData);
        checkStore(name, 1'b0, '0, '0, memWrEn, memAddr, memWrData);
    endtask

    task automatic genProgram();
        int pick;
        int ahead;
        progLen = randRange(60, 200);
        for (int i = 0; i < progLen - 1; i++) begin
            pick = randRange(0, 15);
            progRd[i]  = regAddrW'($urandom);
            progRs1[i] = regAddrW'($urandom);
            progRs2[i] = regAddrW'($urandom);
            progImm[i] = xlen'(randRange(-32, 31));
            case (pick)
                0, 1, 2, 3, 4: progKind[i] = insKindT'(pick);
                5, 6, 7:       progKind[i] = insAddi;
                8, 9:          progKind[i] = insLw;
                10, 11:        progKind[i] = insSw;
                12, 13:        progKind[i] = insBeq;
                default:       progKind[i] = insBad;
            endcase
            if (progKind[i] inside {insLw, insSw}) begin
                progRs1[i] = '0;
                progImm[i] = xlen'(4 * randRange(0, 15));   // Small window so loads hit stores
            end else if (progKind[i] == insBeq) begin
                ahead = (progLen - 1 - i < 8) ? progLen - 1 - i : 8;
                progImm[i] = xlen'(4 * randRange(1, ahead));
                if (randRange(0, 1) == 1) begin
                    progRs2[i] = progRs1[i];    // Forces a taken branch
                end
            end
            if (progKind[i] == insBad) begin
                progWord[i] = {25'($urandom), badOps[randRange(0, 3)]};
            end else begin
                progWord[i] = encodeInst(progKind[i], progRd[i], progRs1[i], progRs2[i],
                    progImm[i]);
            end
        end
        // beq x0,x0,0
        progKind[progLen-1] = insBeq;
        progRd[progLen-1]   = '0;
        progRs1[progLen-1]  = '0;
        progRs2[progLen-1]  = '0;
        progImm[progLen-1]  = '0;
        progWord[progLen-1] = encodeInst(insBeq, '0, '0, '0, '0);
        finalPc = xlen'(4 * (progLen - 1));
    endtask

    task automatic modelStep();
        int              idx;
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] res;
        logic            writes;
        idx     = int'(modelPc >> 2);
        a       = modelRegs[progRs1[idx]];
        b       = modelRegs[progRs2[idx]];
        addr    = a + progImm[idx];
        res     = '0;
        writes  = 1'b1;
        expPc   = modelPc;
        expInst = progWord[idx];
        expStEn = 1'b0;
        modelPc = modelPc + 4;
        case (progKind[idx])
            insAdd:  res = a + b;
            insSub:  res = a - b;
            insAnd:  res = a & b;
            insOr:   res = a | b;
            insSlt:  res = xlen'($signed(a) < $signed(b));
            insAddi: res = a + progImm[idx];
            insLw:   res = modelMem[addr[7:2]];
            insSw: begin
                writes    = 1'b0;
                expStEn   = 1'b1;
                expStAddr = addr;
                expStData = b;
                modelMem[addr[7:2]] = b;
            end
            insBeq: begin
                writes = 1'b0;
                if (a == b) begin
                    modelPc = expPc + progImm[idx];
                end
            end
            default: writes = 1'b0;    // Unsupported opcode
        endcase
        expWbEn   = writes && progRd[idx] != '0;
        expWbAddr = progRd[idx];
        expWbData = res;
        if (expWbEn) begin
            modelRegs[progRd[idx]] = res;
        end
    endtask

    task automatic resetDut();
        @(posedge CLK);
        #10;
        arstN    = 1'b0;
        runEn    = 1'b0;
        imemWrEn = 1'b0;
        repeat (5) @(posedge CLK);
        #10;
        arstN   = 1'b1;
        modelPc = '0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        for (int i = 0; i < dmemDepth; i++) begin
            modelMem[i] = '0;
        end
    endtask

    task automatic loadProgram(input int progNum);
        for (int i = 0; i < progLen; i++) begin
            @(posedge CLK);
            #10;
            imemWrEn   = 1'b1;
            imemWrAddr = imemAddrW'(i);
            imemWrData = progWord[i];
            @(negedge CLK);
            checkIdle($sformatf("prog%0d load%0d", progNum, i));
        end
        @(posedge CLK);
        #10;
        imemWrEn = 1'b0;
    endtask

    task automatic runProgram(input int progNum);
        int    cycles;
        int    stallLeft;
        int    tail;
        string tag;
        cycles    = 0;
        stallLeft = 0;
        tail      = 0;
        while (tail < 3) begin
            if (cycles >= 1000) begin
                $display("Program %0d did not reach its final loop within 1000 cycles",
                    progNum);
                stopRun();
            end
            if (stallLeft == 0 && randRange(0, 11) == 0) begin
                stallLeft = randRange(1, 4);
            end
            @(posedge CLK);
            #10;
            runEn = (stallLeft == 0);
            @(negedge CLK);
            tag = $sformatf("prog%0d cycle%0d", progNum, cycles);
            if (stallLeft > 0) begin
                stallLeft--;
                checkIdle(tag);
                checkPc(tag, modelPc, tracePc);     // Frozen while stalled
            end else begin
                modelStep();
                checkValid(tag, 1'b1, traceValid);
                checkPc(tag, expPc, tracePc);
                checkInst(tag, expInst, traceInst);
                checkWb(tag, expWbEn, expWbAddr, expWbData, wbEn, wbAddr, wbData);
                checkStore(tag, expStEn, expStAddr, expStData, memWrEn, memAddr, memWrData);
                if (expPc == finalPc) begin
                    tail++;
                end
            end
            cycles++;
        end
        @(posedge CLK);
        #10;
        runEn = 1'b0;
    endtask

    initial begin
        void'($urandom(32'hbaa6_1bd4));
        arstN      = 1'b0;
        runEn      = 1'b0;
        imemWrEn   = 1'b0;
        imemWrAddr = '0;
        imemWrData = '0;
        for (int p = 1; p <= 3; p++) begin
            genProgram();
            resetDut();
            loadProgram(p);
            runProgram(p);
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu
    import cpuPkg::*;
(
    input  aluOpT                aluOp,
    input  wire logic [xlen-1:0] opA,
    input  wire logic [xlen-1:0] opB,
    output logic      [xlen-1:0] result,
    output logic                 zero
);

    logic signedLess;

    assign signedLess = $signed(opA) < $signed(opB);

    always_comb begin
        case (aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluSlt:  result = {{(xlen-1){1'b0}}, signedLess};
            default: result = opA + opB;
        endcase
    end

    // Branch compare flag
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: verilog/dataMem.sv
`timescale 1ns/100ps
`default_nettype none

module dataMem
    import cpuPkg::*;
(
    input  wire logic            CLK,
    input  wire logic            arstN,
    input  wire logic            wrEn,
    input  wire logic [xlen-1:0] addr,
    input  wire logic [xlen-1:0] wrData,
    output logic      [xlen-1:0] rdData
);

    logic [xlen-1:0]      mem [dmemDepth];
    logic [dmemAddrW-1:0] wordIdx;

    // Upper address bits ignored so accesses wrap
    assign wordIdx = addr[dmemAddrW+1:2];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < dmemDepth; i++) begin
                mem[i] <= '0;
            end
        end else if (wrEn) begin
            mem[wordIdx] <= wrData;
        end
    end

    assign rdData = mem[wordIdx];   // Combinational read for lw

endmodule

`default_nettype wire

// File: verilog/decodeControl.sv
`timescale 1ns/100ps
`default_nettype none

module decodeControl
    import cpuPkg::*;
(
    input  wire logic [xlen-1:0]     inst,
    output logic      [regAddrW-1:0] rs1Addr,
    output logic      [regAddrW-1:0] rs2Addr,
    output logic      [regAddrW-1:0] rdAddr,
    output logic                     regWrite,
    output logic                     memWrite,
    output logic                     memToReg,
    output logic                     aluSrc,
    output logic                     branch,
    output aluOpT                    aluOp,
    output logic      [xlen-1:0]     imm
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;   // inst[30] picks sub over add

    assign opcode   = opcodeT'(inst[6:0]);
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];

    assign rs1Addr = inst[19:15];
    assign rs2Addr = inst[24:20];
    assign rdAddr  = inst[11:7];

    always_comb begin
        regWrite = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        aluOp    = aluAdd;
        imm      = '0;
        case (opcode)
            opR: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluOp = funct7b5 ? aluSub : aluAdd;
                    3'b010:  aluOp = aluSlt;
                    3'b110:  aluOp = aluOr;
                    3'b111:  aluOp = aluAnd;
                    default: aluOp = aluAdd;
                endcase
            end
            opImm: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                imm      = {{20{inst[31]}}, inst[31:20]};   // I form
            end
            opLoad: begin
                regWrite = 1'b1;
                memToReg = 1'b1;
                aluSrc   = 1'b1;
                imm      = {{20{inst[31]}}, inst[31:20]};
            end
            opStore: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                imm      = {{20{inst[31]}}, inst[31:25], inst[11:7]};   // S form
            end
            opBranch: begin
                branch = 1'b1;
                aluOp  = aluSub;   // Equal operands give zero
                // B form with the low bit always zero
                imm    = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            end
            default: begin
                // Unsupported opcode retires as a no-op
                regWrite = 1'b0;
                memWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/fetchUnit.sv
`timescale 1ns/100ps
`default_nettype none

module fetchUnit
    import cpuPkg::*;
(
    input  wire logic            CLK,
    input  wire logic            arstN,
    input  wire logic            runEn,
    input  wire logic            branchTaken,
    input  wire logic [xlen-1:0] imm,
    output logic      [xlen-1:0] pc
);

    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] pcTarget;
    logic [xlen-1:0] pcNext;

    assign pcPlus4  = pc + xlen'(4);
    assign pcTarget = pc + imm;     // Branch offset already shifted by decode

    always_comb begin
        if (branchTaken) begin
            pcNext = pcTarget;
        end else begin
            pcNext = pcPlus4;
        end
    end

    // Holds while stalled
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (runEn) begin
            pc <= pcNext;
        end
    end

    // Every branch target must land on a word
    pcAligned : assert property (@(posedge CLK) disable iff (!arstN)
        runEn |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: verilog/instMem.sv
`timescale 1ns/100ps
`default_nettype none

module instMem
    import cpuPkg::*;
(
    input  wire logic                 CLK,
    input  wire logic                 imemWrEn,
    input  wire logic [imemAddrW-1:0] imemWrAddr,
    input  wire logic [xlen-1:0]      imemWrData,
    input  wire logic [xlen-1:0]      pc,
    output logic      [xlen-1:0]      inst
);

    // Zero words decode as no-ops
    logic [xlen-1:0] mem [imemDepth] = '{default: '0};

    // Loader port writes one word per strobe
    always_ff @(posedge CLK) begin
        if (imemWrEn) begin
            mem[imemWrAddr] <= imemWrData;
        end
    end

    assign inst = mem[pc[imemAddrW+1:2]];  // Byte PC to word index

endmodule

`default_nettype wire

// File: verilog/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile
    import cpuPkg::*;
(
    input  wire logic                CLK,
    input  wire logic                arstN,
    input  wire logic                wrEn,
    input  wire logic [regAddrW-1:0] rs1Addr,
    input  wire logic [regAddrW-1:0] rs2Addr,
    input  wire logic [regAddrW-1:0] rdAddr,
    input  wire logic [xlen-1:0]     wrData,
    output logic      [xlen-1:0]     rs1Data,
    output logic      [xlen-1:0]     rs2Data
);

    // x0 has storage but never takes a write
    logic [xlen-1:0] regs [2**regAddrW];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 2**regAddrW; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && rdAddr != '0) begin
            regs[rdAddr] <= wrData;
        end
    end

    assign rs1Data = regs[rs1Addr];
    assign rs2Data = regs[rs2Addr];

    // A stray write to x0 would show up on either read port
    x0Zero : assert property (@(posedge CLK) disable iff (!arstN)
        (rs1Addr != '0 || rs1Data == '0) && (rs2Addr != '0 || rs2Data == '0));

endmodule

`default_nettype wire

// File: verilog/singleCpu.sv
`timescale 1ns/100ps
`default_nettype none

module singleCpu
    import cpuPkg::*;
(
    input  wire logic                 CLK,
    input  wire logic                 arstN,
    input  wire logic                 runEn,
    input  wire logic                 imemWrEn,
    input  wire logic [imemAddrW-1:0] imemWrAddr,
    input  wire logic [xlen-1:0]      imemWrData,
    output logic                      traceValid,
    output logic                      wbEn,
    output logic                      memWrEn,
    output logic      [xlen-1:0]      tracePc,
    output logic      [xlen-1:0]      traceInst,
    output logic      [xlen-1:0]      wbData,
    output logic      [xlen-1:0]      memAddr,
    output logic      [xlen-1:0]      memWrData,
    output logic      [regAddrW-1:0]  wbAddr
);

    logic [xlen-1:0]     pc;
    logic [xlen-1:0]     inst;
    logic [regAddrW-1:0] rs1Addr;
    logic [regAddrW-1:0] rs2Addr;
    logic [regAddrW-1:0] rdAddr;
    logic                regWrite;
    logic                memWrite;
    logic                memToReg;
    logic                aluSrc;
    logic                branch;
    aluOpT               aluOp;
    logic [xlen-1:0]     imm;
    logic [xlen-1:0]     rs1Data;
    logic [xlen-1:0]     rs2Data;
    logic [xlen-1:0]     opB;
    logic [xlen-1:0]     result;
    logic                zero;
    logic [xlen-1:0]     readData;
    logic [xlen-1:0]     wbValue;
    logic                branchTaken;

    fetchUnit i_fetchUnit (
        .CLK(CLK), .arstN(arstN), .runEn(runEn),
        .branchTaken(branchTaken), .imm(imm), .pc(pc)
    );

    instMem i_instMem (
        .CLK(CLK), .imemWrEn(imemWrEn), .imemWrAddr(imemWrAddr),
        .imemWrData(imemWrData), .pc(pc), .inst(inst)
    );

    decodeControl i_decodeControl (
        .inst(inst), .rs1Addr(rs1Addr), .rs2Addr(rs2Addr), .rdAddr(rdAddr),
        .regWrite(regWrite), .memWrite(memWrite), .memToReg(memToReg),
        .aluSrc(aluSrc), .branch(branch), .aluOp(aluOp), .imm(imm)
    );

    regFile i_regFile (
        .CLK(CLK), .arstN(arstN), .wrEn(wbEn), .rs1Addr(rs1Addr),
        .rs2Addr(rs2Addr), .rdAddr(rdAddr), .wrData(wbValue),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    assign opB = aluSrc ? imm : rs2Data;    // Immediate forms use imm

    alu i_alu (
        .aluOp(aluOp), .opA(rs1Data), .opB(opB), .result(result), .zero(zero)
    );

    dataMem i_dataMem (
        .CLK(CLK), .arstN(arstN), .wrEn(memWrEn), .addr(result),
        .wrData(rs2Data), .rdData(readData)
    );

    assign wbValue     = memToReg ? readData : result;
    assign branchTaken = branch & zero;

    // Nothing retires unless running
    assign traceValid = runEn;
    assign wbEn       = runEn && regWrite && rdAddr != '0;
    assign memWrEn    = runEn && memWrite;

    assign tracePc   = pc;
    assign traceInst = inst;
    assign wbAddr    = rdAddr;
    assign wbData    = wbValue;
    assign memAddr   = result;
    assign memWrData = rs2Data;

    // Program load and execution never overlap
    noLoadWhileRun : assert property (@(posedge CLK) disable iff (!arstN)
        !(imemWrEn && runEn));

endmodule

`default_nettype wire
